/* upd78_core.f */
+incdir+src
src/upd78_pkg.sv
src/upd78_decode.sv
src/upd78_alu.sv
src/upd78_regfile.sv
src/upd78_core.sv
sim/upd78_core_properties.sv
sim/upd78_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the upd78_core testbench with Verilator and runs it.
# Exits non-zero when the build or the run breaks, or when the log
# reports a failing check.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module upd78_core_tb \
  -f upd78_core.f -o upd78_core_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/upd78_core_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

/* sim/upd78_core_tb.sv */
// Testbench for the uPD7800-style core.
// Builds a random program from an LFSR, runs an instruction-level model
// of it ahead of time, then checks every fetch address and every store
// of the DUT against that model. Compile with the file list in the root.

`timescale 1ns/100ps
`default_nettype none

module upd78_core_tb;

  import upd78_pkg::*;

  // program starts away from address zero
  localparam word_t RESET_PC     = 16'h0240;
  localparam int    N_INSTR      = 200;
  localparam int    RESET_CYCLES = 10;
  localparam int    CYCLE_LIMIT  = N_INSTR * 4 + 100;

  logic        CLK = 1'b0;
  logic        rst_n = 1'b0;
  word_t       addr;
  byte_t       db_i;
  byte_t       db_o;
  logic        db_oe;
  logic        m1;

  byte_t       mem [65536];
  logic [31:0] lfsr;
  word_t       instr_addr [N_INSTR+1];
  word_t       end_addr;

  // expected bus traffic from the model
  word_t       fetch_q [$];
  word_t       store_addr_q [$];
  byte_t       store_data_q [$];
  int          model_stores = 0;
  int          stores_seen = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  logic        done = 1'b0;
  logic        first_fetch = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // clock, DUT and program memory

  initial begin
    forever #5 CLK = ~CLK;
  end

  upd78_core #(
    .RESET_PC (RESET_PC)
  ) upd78_core_i (
    .CLK   (CLK),
    .rst_n (rst_n),
    .A     (addr),
    .DB_I  (db_i),
    .DB_O  (db_o),
    .DB_OE (db_oe),
    .M1    (m1)
  );

  // combinational read in the same cycle as the address
  assign db_i = mem[addr];

  //////////////////////////////////////////////////////////////////////
  // program generator

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic int instr_len(input logic [4:0] op);
    if (op == OP_MVI) begin
      return 2;
    end
    if (op == OP_JMP) begin
      return 3;
    end
    return 1;
  endfunction

  // opcodes first so jump targets know where every instruction lands
  task automatic build_program();
    logic [4:0] ops [N_INSTR];
    logic [2:0] regs [N_INSTR];
    logic [3:0] pick;
    word_t      pc;
    byte_t      imm;
    int         tgt;
    // background fill mixes both address bytes
    for (int i = 0; i < 65536; i++) begin
      mem[i] = byte_t'(i[15:8]) ^ byte_t'(i[7:0]) ^ 8'ha5;
    end
    for (int i = 0; i < N_INSTR; i++) begin
      pick = 4'(rand_bits(4));
      regs[i] = 3'(rand_bits(3));
      case (pick)
        4'd13, 4'd14: ops[i] = OP_STAX;
        // a few undefined opcodes that run as nop
        4'd15:        ops[i] = 5'd13 + 5'(rand_bits(3));
        default:      ops[i] = {1'b0, pick};
      endcase
      // H only ever written through MVI and kept high there
      if (ops[i] == OP_MOV_RA && regs[i] == R_H) begin
        regs[i] = R_L;
      end
    end
    // stores land well above the code
    ops[0] = OP_MVI;
    regs[0] = R_H;
    pc = RESET_PC;
    for (int i = 0; i < N_INSTR; i++) begin
      instr_addr[i] = pc;
      pc = pc + word_t'(instr_len(ops[i]));
    end
    instr_addr[N_INSTR] = pc;
    end_addr = pc;
    for (int i = 0; i < N_INSTR; i++) begin
      pc = instr_addr[i];
      mem[pc] = {ops[i], regs[i]};
      if (ops[i] == OP_MVI) begin
        imm = byte_t'(rand_bits(8));
        if (regs[i] == R_H) begin
          imm[7] = 1'b1;
        end
        mem[pc + 16'd1] = imm;
      end else if (ops[i] == OP_JMP) begin
        // forward only so the run always reaches the end
        tgt = i + 1 + int'(rand_bits(3));
        if (tgt > N_INSTR) begin
          tgt = N_INSTR;
        end
        mem[pc + 16'd1] = instr_addr[tgt][7:0];
        mem[pc + 16'd2] = instr_addr[tgt][15:8];
      end
    end
    // closing jump to itself
    mem[end_addr] = {OP_JMP, 3'b000};
    mem[end_addr + 16'd1] = end_addr[7:0];
    mem[end_addr + 16'd2] = end_addr[15:8];
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction-level model

  task automatic run_model();
    byte_t r [8];
    byte_t op;
    byte_t b;
    byte_t corr;
    word_t pc;
    logic  cy;
    logic  hc;
    logic  lo_adj;
    logic  hi_adj;
    int    cin;
    for (int i = 0; i < 8; i++) begin
      r[i] = 8'h00;
    end
    cy = 1'b0;
    hc = 1'b0;
    pc = RESET_PC;
    fetch_q.push_back(pc);
    while (pc != end_addr) begin
      op = mem[pc];
      b = r[op[2:0]];
      pc = pc + 16'd1;
      case (op[7:3])
        OP_MOV_AR: r[0] = b;
        OP_MOV_RA: r[op[2:0]] = r[0];
        OP_MVI: begin
          r[op[2:0]] = mem[pc];
          pc = pc + 16'd1;
        end
        OP_ADD, OP_ADC: begin
          cin = (op[7:3] == OP_ADC) ? int'(cy) : 0;
          hc = (int'(r[0][3:0]) + int'(b[3:0]) + cin) > 15;
          cy = (int'(r[0]) + int'(b) + cin) > 255;
          r[0] = r[0] + b + byte_t'(cin);
        end
        // flags report borrow
        OP_SUB: begin
          hc = r[0][3:0] < b[3:0];
          cy = r[0] < b;
          r[0] = r[0] - b;
        end
        // logic ops leave the flags alone
        OP_AND: r[0] = r[0] & b;
        OP_OR:  r[0] = r[0] | b;
        OP_XOR: r[0] = r[0] ^ b;
        OP_DAA: begin
          lo_adj = (r[0][3:0] > 4'h9) || hc;
          hi_adj = (r[0] > 8'h99) || cy;
          corr = {(hi_adj ? 4'h6 : 4'h0), (lo_adj ? 4'h6 : 4'h0)};
          hc = (int'(r[0][3:0]) + int'(corr[3:0])) > 15;
          cy = cy || hi_adj;
          r[0] = r[0] + corr;
        end
        OP_STAX: begin
          store_addr_q.push_back({r[R_H], r[R_L]});
          store_data_q.push_back(r[0]);
          model_stores++;
        end
        OP_JMP: pc = {mem[pc + 16'd1], mem[pc]};
        default: ;
      endcase
      fetch_q.push_back(pc);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reset_outputs();
    if (m1 !== 1'b0 || db_oe !== 1'b0) begin
      other_errors++;
      $display("M1 or DB_OE not low during reset at %0t", $time);
    end
  endtask

  task automatic check_fetch();
    word_t exp;
    if (fetch_q.size() == 0) begin
      other_errors++;
      $display("fetch at %0t with no instruction left in the model", $time);
    end else begin
      exp = fetch_q.pop_front();
      if (first_fetch) begin
        check_word(addr, exp, "first fetch after reset");
      end else begin
        check_word(addr, exp, "fetch address");
      end
      first_fetch = 1'b0;
      // last model fetch is the closing self-jump
      if (fetch_q.size() == 0) begin
        if (stores_seen != model_stores || store_addr_q.size() != 0) begin
          mismatches++;
          $display("Mismatch at %0t: %0d stores seen, expected %0d",
                   $time, stores_seen, model_stores);
        end
        done = 1'b1;
      end
    end
  endtask

  task automatic check_store();
    if (store_addr_q.size() == 0) begin
      other_errors++;
      $display("DB_OE pulse at %0t with no store left in the model", $time);
    end else begin
      check_word(addr, store_addr_q.pop_front(), "store address");
      check_byte(db_o, store_data_q.pop_front(), "store data");
      stores_seen++;
    end
  endtask

  task automatic watch_bus();
    if (m1 === 1'b1) begin
      check_fetch();
    end
    if (db_oe === 1'b1) begin
      check_store();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int cycles;
    int timeouts;
    cycles = 0;
    timeouts = 0;
    lfsr = 32'h76c5;
    build_program();
    run_model();
    // outputs sampled on the falling edge away from the flops
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge CLK);
      check_reset_outputs();
    end
    @(posedge CLK);
    rst_n <= 1'b1;
    while (!done && cycles < CYCLE_LIMIT) begin
      @(negedge CLK);
      cycles++;
      watch_bus();
    end
    if (!done) begin
      timeouts = 1;
      $display("timeout: core did not reach the closing self-jump in %0d cycles",
               CYCLE_LIMIT);
    end
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors + timeouts);
    if (mismatches == 0 && other_errors + timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/upd78_core_properties.sv */
// Bus-protocol assertions for the uPD7800-style core.
// Bound to every upd78_core instance by the bind at the bottom,
// so the testbench needs no extra wiring.

`timescale 1ns/100ps
`default_nettype none

module upd78_core_properties (
  input wire                    CLK,
  input wire                    rst_n,
  input wire upd78_pkg::word_t  A,
  input wire                    DB_OE,
  input wire                    M1
);

  import upd78_pkg::*;

  word_t a_mid;

  // address seen halfway through each cycle
  always @(negedge CLK) begin
    a_mid <= A;
  end

  // a cycle is either a fetch or a store, never both
  fetch_store_excl: assert property (@(posedge CLK) disable iff (!rst_n) !(M1 && DB_OE))
    else $error("M1 and DB_OE high in the same cycle");

  // bus stays quiet while the core sits in reset
  reset_quiet: assert property (@(posedge CLK) !rst_n |=> (!M1 && !DB_OE))
    else $error("M1 or DB_OE active after a reset edge");

  // write address holds for the whole store cycle
  store_addr_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    DB_OE |-> (A == a_mid))
    else $error("A changed during a DB_OE cycle");

endmodule

bind upd78_core upd78_core_properties upd78_core_properties_i (
  .CLK   (CLK),
  .rst_n (rst_n),
  .A     (A),
  .DB_OE (DB_OE),
  .M1    (M1)
);

`default_nettype wire

/* src/upd78_core.sv */
// Top level of the uPD7800-style core.
// Ties decode, ALU and register file together around the internal
// data bus. Program memory sits outside on A, DB_I, DB_O, DB_OE and M1.

`timescale 1ns/100ps
`default_nettype none

module upd78_core #(
  parameter upd78_pkg::word_t RESET_PC = 16'h0000
) (
  input  wire                     CLK,
  input  wire                     rst_n,
  output wire upd78_pkg::word_t   A,
  input  wire upd78_pkg::byte_t   DB_I,
  output wire upd78_pkg::byte_t   DB_O,
  output wire                     DB_OE,
  output wire                     M1
);

  import upd78_pkg::*;

  byte_t  idb;
  byte_t  rf_out;
  byte_t  rf_h;
  byte_t  rf_l;
  byte_t  alu_out;
  e_idbs  idbs;
  e_rsel  rsel;
  e_aluop aluop;
  logic   rf_we;
  logic   psw_we;
  logic   ai_le;
  logic   bi_le;
  logic   cy_out;
  logic   hc_out;
  logic   cy;
  logic   hc;

  // internal data bus
  always_comb begin
    case (idbs)
      IDBS_RF:  idb = rf_out;
      IDBS_DB:  idb = DB_I;
      IDBS_ALU: idb = alu_out;
      default:  idb = 8'h00;
    endcase
  end

  upd78_decode #(
    .RESET_PC (RESET_PC)
  ) upd78_decode_i (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .idb    (idb),
    .rf_h   (rf_h),
    .rf_l   (rf_l),
    .A      (A),
    .M1     (M1),
    .DB_OE  (DB_OE),
    .idbs   (idbs),
    .rsel   (rsel),
    .rf_we  (rf_we),
    .psw_we (psw_we),
    .ai_le  (ai_le),
    .bi_le  (bi_le),
    .aluop  (aluop)
  );

  upd78_alu upd78_alu_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .idb     (idb),
    .ai_le   (ai_le),
    .bi_le   (bi_le),
    .aluop   (aluop),
    .cy_in   (cy),
    .hc_in   (hc),
    .alu_out (alu_out),
    .cy_out  (cy_out),
    .hc_out  (hc_out)
  );

  // carry loops back to the ALU for ADC and DAA
  upd78_regfile upd78_regfile_i (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .idb    (idb),
    .rsel   (rsel),
    .rf_we  (rf_we),
    .psw_we (psw_we),
    .cy_out (cy_out),
    .hc_out (hc_out),
    .rf_out (rf_out),
    .rf_h   (rf_h),
    .rf_l   (rf_l),
    .DB_O   (DB_O),
    .cy     (cy),
    .hc     (hc)
  );

endmodule

`default_nettype wire

/* src/upd78_regfile.sv */
// Register file of the uPD7800-style core.
// Eight general registers A V B C D E H L plus carry and half-carry of
// the PSW. Written from the internal data bus, read through one port
// selected by decode. H and L feed the store address, A the data out.

`timescale 1ns/100ps
`default_nettype none

module upd78_regfile (
  input  wire                     CLK,
  input  wire                     rst_n,
  input  wire upd78_pkg::byte_t   idb,
  input  wire upd78_pkg::e_rsel   rsel,
  input  wire                     rf_we,
  input  wire                     psw_we,
  input  wire                     cy_out,
  input  wire                     hc_out,
  output upd78_pkg::byte_t        rf_out,
  output upd78_pkg::byte_t        rf_h,
  output upd78_pkg::byte_t        rf_l,
  output upd78_pkg::byte_t        DB_O,
  output logic                    cy,
  output logic                    hc
);

  import upd78_pkg::*;

  byte_t rf [8];

  //////////////////////////////////////////////////////////////////////
  // general registers

  // registers start out at zero
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        rf[i] <= 8'h00;
      end
    end else if (rf_we) begin
      rf[rsel] <= idb;
    end
  end

  // read port onto idb
  assign rf_out = rf[rsel];

  // store address halves
  assign rf_h = rf[R_H];
  assign rf_l = rf[R_L];

  // store data is always the accumulator
  assign DB_O = rf[R_A];

  //////////////////////////////////////////////////////////////////////
  // psw

  // flags follow the ALU on write-back only
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cy <= 1'b0;
      hc <= 1'b0;
    end else if (psw_we) begin
      cy <= cy_out;
      hc <= hc_out;
    end
  end

endmodule

`default_nettype wire

/* src/upd78_alu.sv */
// 8-bit ALU of the uPD7800-style core.
// Latches its operands from the internal data bus and produces the
// result and flags combinationally from those latches, so the result
// can go back on the bus one step after the last operand load.

`timescale 1ns/100ps
`default_nettype none

module upd78_alu (
  input  wire                     CLK,
  input  wire                     rst_n,
  input  wire upd78_pkg::byte_t   idb,
  input  wire                     ai_le,
  input  wire                     bi_le,
  input  wire upd78_pkg::e_aluop  aluop,
  input  wire                     cy_in,
  input  wire                     hc_in,
  output upd78_pkg::byte_t        alu_out,
  output logic                    cy_out,
  output logic                    hc_out
);

  import upd78_pkg::*;

  byte_t      ai;
  byte_t      bi;
  byte_t      bop;
  byte_t      sum;
  e_aluop     op_q;
  logic       cin;
  logic       pdal;
  logic       pdah;
  logic [4:0] lsum;
  logic [4:0] hsum;

  //////////////////////////////////////////////////////////////////////
  // operand latches

  always_ff @(posedge CLK) begin
    if (ai_le) begin
      ai <= idb;
    end
    if (bi_le) begin
      bi <= idb;
    end
  end

  // operation rides in with the B operand
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      op_q <= ALU_NONE;
    end else if (bi_le) begin
      op_q <= aluop;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // adder input

  // decimal adjust needs
  assign pdal = (ai[3:0] > 4'h9) | hc_in;
  assign pdah = (ai > 8'h99) | cy_in;

  always_comb begin
    bop = bi;
    cin = 1'b0;
    case (op_q)
      ALU_ADC: cin = cy_in;
      // two's complement subtract
      ALU_SUB: begin
        bop = ~bi;
        cin = 1'b1;
      end
      ALU_DAA: bop = {(pdah ? 4'h6 : 4'h0), (pdal ? 4'h6 : 4'h0)};
      default: ;
    endcase
  end

  // split at the nibble for half-carry
  assign lsum = {1'b0, ai[3:0]} + {1'b0, bop[3:0]} + {4'b0000, cin};
  assign hsum = {1'b0, ai[7:4]} + {1'b0, bop[7:4]} + {4'b0000, lsum[4]};
  assign sum  = {hsum[3:0], lsum[3:0]};

  //////////////////////////////////////////////////////////////////////
  // result and flags

  // flags pass through untouched unless the op defines them
  always_comb begin
    alu_out = ai;
    cy_out  = cy_in;
    hc_out  = hc_in;
    case (op_q)
      ALU_ADD, ALU_ADC: begin
        alu_out = sum;
        cy_out  = hsum[4];
        hc_out  = lsum[4];
      end
      // carry out low means borrow
      ALU_SUB: begin
        alu_out = sum;
        cy_out  = ~hsum[4];
        hc_out  = ~lsum[4];
      end
      ALU_AND: alu_out = ai & bi;
      ALU_OR:  alu_out = ai | bi;
      ALU_XOR: alu_out = ai ^ bi;
      ALU_DAA: begin
        alu_out = sum;
        cy_out  = cy_in | pdah;
        hc_out  = lsum[4];
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* src/upd78_decode.sv */
// Instruction decode and micro-sequencer for the uPD7800-style core.
// Holds pc, the register field of the opcode, the micro-address pointer
// and the address output register, and turns the current microword into
// the bus selects and strobes used by the rest of the core.

`timescale 1ns/100ps
`default_nettype none

module upd78_decode #(
  parameter upd78_pkg::word_t RESET_PC = 16'h0000
) (
  input  wire                     CLK,
  input  wire                     rst_n,
  input  wire upd78_pkg::byte_t   idb,
  input  wire upd78_pkg::byte_t   rf_h,
  input  wire upd78_pkg::byte_t   rf_l,
  output upd78_pkg::word_t        A,
  output logic                    M1,
  output logic                    DB_OE,
  output upd78_pkg::e_idbs        idbs,
  output upd78_pkg::e_rsel        rsel,
  output logic                    rf_we,
  output logic                    psw_we,
  output logic                    ai_le,
  output logic                    bi_le,
  output upd78_pkg::e_aluop       aluop
);

  import upd78_pkg::*;

`include "upd78_ucode.svh"

  s_uc    uc;
  e_uaddr uptr;
  e_uaddr uptr_next;
  word_t  pc;
  word_t  pc_next;
  word_t  aor;
  byte_t  jmp_lo;
  e_rsel  ir_rs;

  //////////////////////////////////////////////////////////////////////
  // micro-sequencer

  // microword straight out of the ROM
  assign uc = ucode_rom(uptr);

  // opcode is still on idb during fetch
  always_comb begin
    case (uc.bm)
      BM_ADV:  uptr_next = e_uaddr'(uptr + 5'd1);
      BM_DISP: uptr_next = dispatch(idb[7:3]);
      default: uptr_next = uc.nua;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // program counter and address output

  always_comb begin
    pc_next = pc;
    if (uc.pc_inc) begin
      pc_next = pc + 16'd1;
    end
    // high byte comes last, low byte already staged
    if (uc.pch_ld) begin
      pc_next = {idb, jmp_lo};
    end
  end

  // aor loads the address for the following step
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      uptr <= UA_IDLE;
      pc   <= RESET_PC;
      aor  <= RESET_PC;
    end else begin
      uptr <= uptr_next;
      pc   <= pc_next;
      aor  <= uc.ab_hl ? {rf_h, rf_l} : pc_next;
    end
  end

  // only the register field is kept
  // the opcode itself was dispatched off the bus
  always_ff @(posedge CLK) begin
    if (uc.lts == LT_IR) begin
      ir_rs <= e_rsel'(idb[2:0]);
    end
    if (uc.pcl_ld) begin
      jmp_lo <= idb;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control strobes

  assign A      = aor;
  assign M1     = uc.m1;
  assign DB_OE  = uc.we;
  assign idbs   = uc.idbs;
  assign aluop  = uc.aluop;
  assign rsel   = uc.rs_ir ? ir_rs : R_A;
  assign rf_we  = (uc.lts == LT_RF) || (uc.lts == LT_RF_PSW);
  assign psw_we = (uc.lts == LT_RF_PSW);
  assign ai_le  = (uc.lts == LT_AI) || (uc.lts == LT_AIBI);
  assign bi_le  = (uc.lts == LT_BI) || (uc.lts == LT_AIBI);

endmodule

`default_nettype wire

/* src/upd78_pkg.sv */
// Shared types for the uPD7800-style core.
// Holds data and address widths, the opcode and register encodings,
// ALU operations, micro-addresses and the microword layout.
// Imported by every RTL module and by the testbench.

`default_nettype none

package upd78_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  //////////////////////////////////////////////////////////////////////
  // instruction set

  // upper five opcode bits
  // the low three bits name the register
  typedef enum logic [4:0] {
    OP_NOP    = 5'd0,
    OP_MOV_AR = 5'd1,
    OP_MOV_RA = 5'd2,
    OP_MVI    = 5'd3,
    OP_ADD    = 5'd4,
    OP_ADC    = 5'd5,
    OP_SUB    = 5'd6,
    OP_AND    = 5'd7,
    OP_OR     = 5'd8,
    OP_XOR    = 5'd9,
    OP_DAA    = 5'd10,
    OP_STAX   = 5'd11,
    OP_JMP    = 5'd12
  } e_opcode;

  typedef enum logic [2:0] {R_A, R_V, R_B, R_C, R_D, R_E, R_H, R_L} e_rsel;

  typedef enum logic [2:0] {
    ALU_NONE, ALU_ADD, ALU_ADC, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_DAA
  } e_aluop;

  //////////////////////////////////////////////////////////////////////
  // microcode

  // who drives the internal data bus
  typedef enum logic [1:0] {IDBS_ZERO, IDBS_RF, IDBS_DB, IDBS_ALU} e_idbs;

  // who takes idb at the end of the step
  typedef enum logic [2:0] {
    LT_NONE, LT_IR, LT_RF, LT_RF_PSW, LT_AI, LT_BI, LT_AIBI
  } e_lts;

  // advance, direct jump, or opcode dispatch
  typedef enum logic [1:0] {BM_ADV, BM_DA, BM_DISP} e_bm;

  // steps linked by BM_ADV must stay adjacent
  typedef enum logic [4:0] {
    UA_IDLE, UA_FETCH, UA_NOP_1, UA_NOP_2,
    UA_MOV_AR_LD, UA_MOV_AR_WB, UA_MOV_RA_LD, UA_MOV_RA_WB,
    UA_MVI_IMM,
    UA_ADD_BI, UA_ADC_BI, UA_SUB_BI, UA_AND_BI, UA_OR_BI, UA_XOR_BI,
    UA_ALU_AI, UA_ALU_WB, UA_DAA_LD,
    UA_STAX_ADR, UA_STAX_WR, UA_JMP_LO, UA_JMP_HI
  } e_uaddr;

  typedef struct packed {
    e_idbs  idbs;
    e_lts   lts;
    logic   rs_ir;   // register from opcode bits, else A
    e_aluop aluop;   // taken by the ALU with bi_le
    logic   pc_inc;
    logic   pcl_ld;  // stage low byte of a jump target
    logic   pch_ld;  // load pc from idb and staged low byte
    logic   ab_hl;   // next address from H and L instead of pc
    logic   we;      // external write strobe
    logic   m1;
    e_bm    bm;
    e_uaddr nua;
  } s_uc;

endpackage

`default_nettype wire

/* src/upd78_ucode.svh */
// Microcode ROM and opcode dispatch table for the decode block.
// Included inside the decode module after the package import.
// Each entry is one CLK cycle of work.

`ifndef UPD78_UCODE_SVH
`define UPD78_UCODE_SVH

// entry point per opcode
// anything unknown goes straight back to fetch
function automatic e_uaddr dispatch(input logic [4:0] op);
  case (e_opcode'(op))
    OP_NOP:    dispatch = UA_NOP_1;
    OP_MOV_AR: dispatch = UA_MOV_AR_LD;
    OP_MOV_RA: dispatch = UA_MOV_RA_LD;
    OP_MVI:    dispatch = UA_MVI_IMM;
    OP_ADD:    dispatch = UA_ADD_BI;
    OP_ADC:    dispatch = UA_ADC_BI;
    OP_SUB:    dispatch = UA_SUB_BI;
    OP_AND:    dispatch = UA_AND_BI;
    OP_OR:     dispatch = UA_OR_BI;
    OP_XOR:    dispatch = UA_XOR_BI;
    OP_DAA:    dispatch = UA_DAA_LD;
    OP_STAX:   dispatch = UA_STAX_ADR;
    OP_JMP:    dispatch = UA_JMP_LO;
    default:   dispatch = UA_FETCH;
  endcase
endfunction

// field order
// idbs lts rs_ir aluop pc_inc pcl_ld pch_ld ab_hl we m1 bm nua
function automatic s_uc ucode_rom(input e_uaddr ua);
  case (ua)
    // opcode fetch, dispatch straight off the bus
    UA_FETCH:     ucode_rom = '{IDBS_DB, LT_IR, 1'b0, ALU_NONE, 1'b1, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b1, BM_DISP, UA_FETCH};
    UA_NOP_1:     ucode_rom = '{IDBS_ZERO, LT_NONE, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_ADV, UA_FETCH};
    UA_NOP_2:     ucode_rom = '{IDBS_ZERO, LT_NONE, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_FETCH};
    // moves pass through the ALU unchanged
    UA_MOV_AR_LD: ucode_rom = '{IDBS_RF, LT_AIBI, 1'b1, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_ADV, UA_FETCH};
    UA_MOV_AR_WB: ucode_rom = '{IDBS_ALU, LT_RF, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_FETCH};
    UA_MOV_RA_LD: ucode_rom = '{IDBS_RF, LT_AIBI, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_ADV, UA_FETCH};
    UA_MOV_RA_WB: ucode_rom = '{IDBS_ALU, LT_RF, 1'b1, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_FETCH};
    UA_MVI_IMM:   ucode_rom = '{IDBS_DB, LT_RF, 1'b1, ALU_NONE, 1'b1, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_FETCH};
    // second operand first, carries the operation into the ALU
    UA_ADD_BI:    ucode_rom = '{IDBS_RF, LT_BI, 1'b1, ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_ALU_AI};
    UA_ADC_BI:    ucode_rom = '{IDBS_RF, LT_BI, 1'b1, ALU_ADC, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_ALU_AI};
    UA_SUB_BI:    ucode_rom = '{IDBS_RF, LT_BI, 1'b1, ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_ALU_AI};
    UA_AND_BI:    ucode_rom = '{IDBS_RF, LT_BI, 1'b1, ALU_AND, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_ALU_AI};
    UA_OR_BI:     ucode_rom = '{IDBS_RF, LT_BI, 1'b1, ALU_OR, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_ALU_AI};
    UA_XOR_BI:    ucode_rom = '{IDBS_RF, LT_BI, 1'b1, ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_ALU_AI};
    UA_ALU_AI:    ucode_rom = '{IDBS_RF, LT_AI, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_ADV, UA_FETCH};
    UA_ALU_WB:    ucode_rom = '{IDBS_ALU, LT_RF_PSW, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_FETCH};
    UA_DAA_LD:    ucode_rom = '{IDBS_RF, LT_AIBI, 1'b0, ALU_DAA, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_ALU_WB};
    // address from H and L lands in the output register first
    UA_STAX_ADR:  ucode_rom = '{IDBS_ZERO, LT_NONE, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b1,
                                1'b0, 1'b0, BM_ADV, UA_FETCH};
    UA_STAX_WR:   ucode_rom = '{IDBS_ZERO, LT_NONE, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b1, 1'b0, BM_DA, UA_FETCH};
    UA_JMP_LO:    ucode_rom = '{IDBS_DB, LT_NONE, 1'b0, ALU_NONE, 1'b1, 1'b1, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_ADV, UA_FETCH};
    UA_JMP_HI:    ucode_rom = '{IDBS_DB, LT_NONE, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b1, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_FETCH};
    // reset parking step
    default:      ucode_rom = '{IDBS_ZERO, LT_NONE, 1'b0, ALU_NONE, 1'b0, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, BM_DA, UA_FETCH};
  endcase
endfunction

`endif
